// ==== hdl/clkgen_pkg.sv ====
// Divider channel types, PWM modes, meter states and register map of the clock generator
package clkgen_pkg;

  localparam int NUM_CH   = 4;   // Channels in the bank
  localparam int CNT_W    = 8;   // Free-running counter per channel
  localparam int TAP_W    = 3;   // Picks one of the CNT_W counter bits
  localparam int GATE_W   = 16;  // Gate length and edge count
  localparam int CH_IDX_W = $clog2(NUM_CH);

  // How many low counter bits the PWM compare uses
  typedef enum logic [1:0] {
    PWM_OFF = 2'd0,  // Output held low
    PWM_2B  = 2'd1,  // Counter bits 1:0 against duty bits 1:0
    PWM_3B  = 2'd2,
    PWM_8B  = 2'd3   // Whole counter
  } pwm_mode_e;

  // Per-channel configuration, 14 bits
  typedef struct packed {
    logic             enable;    // Counter runs while set
    pwm_mode_e        pwm_mode;
    logic [TAP_W-1:0] tap;       // Counter bit driven onto div_out
    logic [CNT_W-1:0] duty;
  } ch_cfg_t;

  typedef enum logic [1:0] {
    M_IDLE,
    M_RUN,   // Gate window open
    M_DONE   // Counts valid until the next start
  } meter_state_e;

  // Byte addresses on the register port
  localparam logic [7:0] ADDR_CH_CFG = 8'h00;  // Channel n at +4n
  localparam logic [7:0] ADDR_GATE   = 8'h20;
  localparam logic [7:0] ADDR_START  = 8'h24;  // Bit 0 starts a gate window
  localparam logic [7:0] ADDR_STATUS = 8'h28;  // Bit 0 busy, bit 1 done
  localparam logic [7:0] ADDR_COUNT  = 8'h30;  // Channel n at +4n, read only

endpackage

// ==== hdl/axil_pkg.sv ====
// AXI4-Lite request and response bundles and response codes
package axil_pkg;

  localparam int AXIL_AW = 8;           // Byte address width
  localparam int AXIL_DW = 32;
  localparam int AXIL_SW = AXIL_DW / 8; // One strobe per byte lane

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10  // Unmapped address
  } resp_e;

  // Manager to subordinate
  typedef struct packed {
    logic               awvalid;
    logic [AXIL_AW-1:0] awaddr;
    logic               wvalid;
    logic [AXIL_DW-1:0] wdata;
    logic [AXIL_SW-1:0] wstrb;
    logic               bready;
    logic               arvalid;
    logic [AXIL_AW-1:0] araddr;
    logic               rready;
  } axil_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic               awready;
    logic               wready;
    logic               bvalid;
    resp_e              bresp;
    logic               arready;
    logic               rvalid;
    logic [AXIL_DW-1:0] rdata;
    resp_e              rresp;
  } axil_rsp_t;

endpackage

// ==== hdl/csr_axil.sv ====
// AXI4-Lite register block holding channel configs and meter controls, reading back edge counts
`timescale 1ns/1ps

module csr_axil
  import clkgen_pkg::*;
  import axil_pkg::*;
(
  input  logic              c0clock,
  input  logic              rst_n,
  input  axil_req_t         req,
  output axil_rsp_t         rsp,
  output ch_cfg_t           cfg [NUM_CH],
  output logic [GATE_W-1:0] gate_len,
  output logic              start,     // One-cycle pulse to the meter
  input  logic [GATE_W-1:0] counts [NUM_CH],
  input  logic              busy,
  input  logic              done
);

  logic        aw_rdy;   // Drives awready and wready together
  logic        ar_rdy;
  logic        bvalid;
  logic        rvalid;
  resp_e       bresp;
  resp_e       rresp;
  logic [31:0] rdata;
  logic        wr_fire;  // Address and data taken this cycle
  logic        rd_fire;

  // Address falls in a block of NUM_CH word registers
  function automatic logic in_block(input logic [7:0] addr, input logic [7:0] base);
    return (addr[7:2] >= base[7:2]) && (addr[7:2] < base[7:2] + 6'(NUM_CH));
  endfunction

  function automatic logic [CH_IDX_W-1:0] ch_index(input logic [7:0] addr,
                                                   input logic [7:0] base);
    return CH_IDX_W'(addr[7:2] - base[7:2]);
  endfunction

  // Byte offset within a word is ignored
  function automatic logic addr_mapped(input logic [7:0] addr);
    return in_block(addr, ADDR_CH_CFG) || in_block(addr, ADDR_COUNT) ||
           (addr[7:2] == ADDR_GATE[7:2]) || (addr[7:2] == ADDR_START[7:2]) ||
           (addr[7:2] == ADDR_STATUS[7:2]);
  endfunction

  function automatic logic [31:0] read_word(input logic [7:0] addr);
    logic [31:0] word;
    ch_cfg_t     c;
    word = '0;  // START and unmapped read as zero
    if (in_block(addr, ADDR_CH_CFG)) begin
      c    = cfg[ch_index(addr, ADDR_CH_CFG)];
      word = {16'h0, c.duty, 1'b0, c.tap, 1'b0, c.pwm_mode, c.enable};
    end else if (in_block(addr, ADDR_COUNT)) begin
      word = 32'(counts[ch_index(addr, ADDR_COUNT)]);
    end else if (addr[7:2] == ADDR_GATE[7:2]) begin
      word = 32'(gate_len);
    end else if (addr[7:2] == ADDR_STATUS[7:2]) begin
      word = {30'h0, done, busy};
    end
    return word;
  endfunction

  assign wr_fire = aw_rdy && req.awvalid && req.wvalid;
  assign rd_fire = ar_rdy && req.arvalid;

  // Write channel and register storage
  always_ff @(posedge c0clock or negedge rst_n) begin
    if (!rst_n) begin
      aw_rdy   <= 1'b0;
      bvalid   <= 1'b0;
      bresp    <= RESP_OKAY;
      start    <= 1'b0;
      gate_len <= '0;
      for (int i = 0; i < NUM_CH; i++) begin
        cfg[i] <= '0;  // All outputs low until configured
      end
    end else begin
      aw_rdy <= req.awvalid && req.wvalid && !bvalid && !aw_rdy;  // Single pulse
      start  <= 1'b0;
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= addr_mapped(req.awaddr) ? RESP_OKAY : RESP_SLVERR;
        if (in_block(req.awaddr, ADDR_CH_CFG)) begin
          if (req.wstrb[0]) begin  // Enable, mode and tap share byte 0
            cfg[ch_index(req.awaddr, ADDR_CH_CFG)].enable   <= req.wdata[0];
            cfg[ch_index(req.awaddr, ADDR_CH_CFG)].pwm_mode <= pwm_mode_e'(req.wdata[2:1]);
            cfg[ch_index(req.awaddr, ADDR_CH_CFG)].tap      <= req.wdata[6:4];
          end
          if (req.wstrb[1]) begin
            cfg[ch_index(req.awaddr, ADDR_CH_CFG)].duty <= req.wdata[15:8];
          end
        end
        if (req.awaddr[7:2] == ADDR_GATE[7:2]) begin
          if (req.wstrb[0]) gate_len[7:0]  <= req.wdata[7:0];   // Low byte
          if (req.wstrb[1]) gate_len[15:8] <= req.wdata[15:8];  // High byte
        end
        if (req.awaddr[7:2] == ADDR_START[7:2] && req.wstrb[0] && req.wdata[0]) begin
          start <= 1'b1;
        end
      end else if (bvalid && req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Read channel control
  always_ff @(posedge c0clock or negedge rst_n) begin
    if (!rst_n) begin
      ar_rdy <= 1'b0;
      rvalid <= 1'b0;
      rresp  <= RESP_OKAY;
    end else begin
      ar_rdy <= req.arvalid && !rvalid && !ar_rdy;
      if (rd_fire) begin
        rvalid <= 1'b1;
        rresp  <= addr_mapped(req.araddr) ? RESP_OKAY : RESP_SLVERR;
      end else if (rvalid && req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge c0clock) begin
    if (rd_fire) rdata <= read_word(req.araddr);  // Held while rvalid waits
  end

  always_comb begin
    rsp.awready = aw_rdy;
    rsp.wready  = aw_rdy;
    rsp.bvalid  = bvalid;
    rsp.bresp   = bresp;
    rsp.arready = ar_rdy;
    rsp.rvalid  = rvalid;
    rsp.rdata   = rdata;
    rsp.rresp   = rresp;
  end

endmodule

// ==== hdl/div_pwm_channel.sv ====
// One divider channel with free-running counter, tapped divided output and PWM compare
`timescale 1ns/1ps

module div_pwm_channel
  import clkgen_pkg::*;
(
  input  logic    c0clock,
  input  logic    rst_n,
  input  ch_cfg_t cfg,
  input  logic    restart,   // From the meter at a gate start
  output logic    div_out,
  output logic    pwm_out
);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] mask;    // Low bits taking part in the compare

  // Counter sits at zero while disabled
  always_ff @(posedge c0clock or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (restart || !cfg.enable) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;  // Wraps freely
    end
  end

  // Bit t toggles every 2**t cycles
  assign div_out = cnt[cfg.tap];

  always_comb begin
    unique case (cfg.pwm_mode)
      PWM_OFF: mask = '0;            // 0 < 0 never holds
      PWM_2B:  mask = CNT_W'(2'b11);
      PWM_3B:  mask = CNT_W'(3'b111);
      default: mask = '1;            // PWM_8B
    endcase
  end

  // Combinational from the counter, so no extra latency
  assign pwm_out = cfg.enable && ((cnt & mask) < (cfg.duty & mask));

endmodule

// ==== hdl/edge_meter.sv ====
// Gate-window edge meter counting rising edges of every divided output
`timescale 1ns/1ps

module edge_meter
  import clkgen_pkg::*;
(
  input  logic              c0clock,
  input  logic              rst_n,
  input  logic              start,
  input  logic [GATE_W-1:0] gate_len,
  input  logic [NUM_CH-1:0] div_out,
  output logic              restart,   // Clears every channel counter
  output logic [GATE_W-1:0] counts [NUM_CH],
  output logic              busy,
  output logic              done
);

  meter_state_e      state;
  logic [GATE_W-1:0] remain;  // Samples left after this one
  logic [NUM_CH-1:0] prev;    // div_out from the previous sample
  logic [NUM_CH-1:0] rise;

  assign busy = (state == M_RUN);
  assign done = (state == M_DONE);

  // Start only taken outside a window
  assign restart = start && (state != M_RUN);
  assign rise    = div_out & ~prev;

  // First run cycle sees the freshly cleared counters and acts as the
  // reference sample, gate_len sampled cycles follow
  always_ff @(posedge c0clock or negedge rst_n) begin
    if (!rst_n) begin
      state  <= M_IDLE;
      remain <= '0;
      prev   <= '0;
      for (int i = 0; i < NUM_CH; i++) begin
        counts[i] <= '0;
      end
    end else begin
      unique case (state)
        M_IDLE, M_DONE: begin
          if (start) begin
            state  <= M_RUN;
            remain <= gate_len;
            prev   <= '0;  // Channels restart low
            for (int i = 0; i < NUM_CH; i++) begin
              counts[i] <= '0;
            end
          end
        end
        M_RUN: begin
          prev <= div_out;
          for (int i = 0; i < NUM_CH; i++) begin
            if (rise[i] && (counts[i] != '1)) counts[i] <= counts[i] + 1'b1;  // Saturates
          end
          if (remain == '0) state <= M_DONE;
          else remain <= remain - 1'b1;
        end
        default: state <= M_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/clkgen_top.sv ====
// Clock generator top with register block, divider channel bank and edge meter
`timescale 1ns/1ps

module clkgen_top
  import clkgen_pkg::*;
  import axil_pkg::*;
(
  input  logic              c0clock,
  input  logic              rst_n,
  input  axil_req_t         req,
  output axil_rsp_t         rsp,
  output logic [NUM_CH-1:0] div_out,
  output logic [NUM_CH-1:0] pwm_out
);

  ch_cfg_t           cfg [NUM_CH];      // Register block to channels
  logic [GATE_W-1:0] gate_len;
  logic              start;
  logic              restart;           // Meter to every channel
  logic [GATE_W-1:0] counts [NUM_CH];   // Meter back to registers
  logic              busy;
  logic              done;

  csr_axil u_csr (
    .c0clock  (c0clock),
    .rst_n    (rst_n),
    .req      (req),
    .rsp      (rsp),
    .cfg      (cfg),
    .gate_len (gate_len),
    .start    (start),
    .counts   (counts),
    .busy     (busy),
    .done     (done)
  );

  // Identical channels, all on c0clock
  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    div_pwm_channel u_ch (
      .c0clock (c0clock),
      .rst_n   (rst_n),
      .cfg     (cfg[i]),
      .restart (restart),
      .div_out (div_out[i]),
      .pwm_out (pwm_out[i])
    );
  end

  edge_meter u_meter (
    .c0clock  (c0clock),
    .rst_n    (rst_n),
    .start    (start),
    .gate_len (gate_len),
    .div_out  (div_out),   // Same nets as the top outputs
    .restart  (restart),
    .counts   (counts),
    .busy     (busy),
    .done     (done)
  );

endmodule

// ==== tests/clkgen_assertions.sv ====
// Bound checker that mirrors register writes and predicts divider, PWM, meter and bus responses
`timescale 1ns/1ps

module clkgen_assertions
  import clkgen_pkg::*;
  import axil_pkg::*;
(
  input logic              c0clock,
  input logic              rst_n,
  input axil_req_t         req,
  input axil_rsp_t         rsp,
  input logic [NUM_CH-1:0] div_out,
  input logic [NUM_CH-1:0] pwm_out
);

  int unsigned       fail_cnt = 0;     // Read by the testbench after each test
  logic [31:0]       m_word [NUM_CH];  // Config words as written, layout bits only
  logic [CNT_W-1:0]  m_cnt [NUM_CH];   // Predicted channel counters
  logic [GATE_W-1:0] m_gate;
  logic [GATE_W-1:0] m_gate_run;       // Gate length of the current window
  logic [GATE_W-1:0] m_left;
  logic              m_start;
  logic              m_run;
  logic              m_done;
  logic              m_restart;
  logic              m_wr_err;
  logic              m_rd_err;         // Last accepted read was unmapped
  logic              m_rd_chk;         // Counts mid-window are not predicted
  logic [31:0]       m_rd_exp;
  logic [NUM_CH-1:0] exp_div;
  logic [NUM_CH-1:0] exp_pwm;
  logic              wr_fire;
  logic              rd_fire;

  function automatic ch_cfg_t cfg_of(input logic [31:0] w);
    return '{enable: w[0], pwm_mode: pwm_mode_e'(w[2:1]), tap: w[6:4], duty: w[15:8]};
  endfunction

  function automatic logic in_blk(input logic [7:0] a, input logic [7:0] base);
    return (a >= base) && (a < base + 8'd16);  // Four word registers
  endfunction

  function automatic logic mapped(input logic [7:0] a);
    return in_blk(a, ADDR_CH_CFG) || in_blk(a, ADDR_COUNT) || a[7:2] == ADDR_GATE[7:2] ||
           a[7:2] == ADDR_START[7:2] || a[7:2] == ADDR_STATUS[7:2];
  endfunction

  // Low bits of counter below low bits of duty
  function automatic logic pwm_expect(input ch_cfg_t c, input logic [CNT_W-1:0] cnt);
    int         bits;
    logic [7:0] m;
    case (c.pwm_mode)
      PWM_2B:  bits = 2;
      PWM_3B:  bits = 3;
      PWM_8B:  bits = 8;
      default: bits = 0;
    endcase
    m = 8'((9'd1 << bits) - 9'd1);
    return c.enable && ((cnt & m) < (c.duty & m));
  endfunction

  // Rising edges of bit tap within g sampled cycles
  function automatic logic [GATE_W-1:0] count_expect(input ch_cfg_t c,
                                                     input logic [GATE_W-1:0] g);
    int p;
    p = 1 << c.tap;
    if (!c.enable || int'(g) < p) return '0;
    return GATE_W'(1 + (int'(g) - p) / (2 * p));
  endfunction

  function automatic logic [31:0] read_expect(input logic [7:0] a);
    logic [1:0] ch;
    ch = a[3:2];  // Word within a four-register block
    if (in_blk(a, ADDR_CH_CFG)) return m_word[ch];
    if (a[7:2] == ADDR_GATE[7:2]) return {16'h0, m_gate};
    if (a[7:2] == ADDR_STATUS[7:2]) return {30'h0, m_done, m_run};
    if (in_blk(a, ADDR_COUNT) && m_done) begin
      return {16'h0, count_expect(cfg_of(m_word[ch]), m_gate_run)};
    end
    return 32'h0;
  endfunction

  assign wr_fire   = req.awvalid && req.wvalid && rsp.awready && rsp.wready;
  assign rd_fire   = req.arvalid && rsp.arready;
  assign m_restart = m_start && !m_run;  // Start inside a window is dropped

  always_ff @(posedge c0clock or negedge rst_n) begin
    if (!rst_n) begin
      m_gate     <= '0;
      m_gate_run <= '0;
      m_left     <= '0;
      m_start    <= 1'b0;
      m_run      <= 1'b0;
      m_done     <= 1'b0;
      m_wr_err   <= 1'b0;
      m_rd_err   <= 1'b0;
      m_rd_chk   <= 1'b0;
      m_rd_exp   <= '0;
      for (int i = 0; i < NUM_CH; i++) begin
        m_word[i] <= '0;
        m_cnt[i]  <= '0;
      end
    end else begin
      m_start <= wr_fire && req.awaddr[7:2] == ADDR_START[7:2] && req.wdata[0];
      if (wr_fire) begin
        m_wr_err <= !mapped(req.awaddr);
        if (in_blk(req.awaddr, ADDR_CH_CFG)) m_word[req.awaddr[3:2]] <= req.wdata & 32'h0000_ff77;
        if (req.awaddr[7:2] == ADDR_GATE[7:2]) m_gate <= req.wdata[15:0];
      end
      if (rd_fire) begin
        m_rd_exp <= read_expect(req.araddr);
        m_rd_err <= !mapped(req.araddr);
        m_rd_chk <= !(in_blk(req.araddr, ADDR_COUNT) && m_run);
      end
      if (m_restart) begin
        m_run      <= 1'b1;
        m_done     <= 1'b0;
        m_left     <= m_gate;
        m_gate_run <= m_gate;
      end else if (m_run) begin
        if (m_left == '0) begin
          m_run  <= 1'b0;  // Reference cycle plus gate length sampled
          m_done <= 1'b1;
        end else begin
          m_left <= m_left - 1'b1;
        end
      end
      for (int i = 0; i < NUM_CH; i++) begin
        m_cnt[i] <= (m_restart || !m_word[i][0]) ? '0 : m_cnt[i] + 1'b1;
      end
    end
  end

  always_comb begin
    ch_cfg_t c;
    for (int i = 0; i < NUM_CH; i++) begin
      c          = cfg_of(m_word[i]);
      exp_div[i] = m_cnt[i][c.tap];  // Toggles every 2**tap cycles
      exp_pwm[i] = pwm_expect(c, m_cnt[i]);
    end
  end

  a_idle: assert property (@(posedge c0clock) $rose(rst_n) |-> div_out == '0 && pwm_out == '0 &&
      !rsp.bvalid && !rsp.rvalid && !rsp.awready && !rsp.wready && !rsp.arready)
    else begin
      fail_cnt++;
      $error("Outputs or handshakes not idle when reset was released");
    end

  a_div: assert property (@(posedge c0clock) disable iff (!rst_n) div_out == exp_div)
    else begin
      fail_cnt++;
      $error("ERROR div_out expected %h got %h", $sampled(exp_div), $sampled(div_out));
    end

  a_pwm: assert property (@(posedge c0clock) disable iff (!rst_n) pwm_out == exp_pwm)
    else begin
      fail_cnt++;
      $error("ERROR pwm_out expected %h got %h", $sampled(exp_pwm), $sampled(pwm_out));
    end

  a_bresp: assert property (@(posedge c0clock) disable iff (!rst_n)
      rsp.bvalid |-> rsp.bresp == (m_wr_err ? RESP_SLVERR : RESP_OKAY))
    else begin
      fail_cnt++;
      $error("ERROR bresp got %h for awaddr error flag %h",
             $sampled(rsp.bresp), $sampled(m_wr_err));
    end

  a_rdata: assert property (@(posedge c0clock) disable iff (!rst_n)
      rsp.rvalid && m_rd_chk |-> rsp.rdata == m_rd_exp)
    else begin
      fail_cnt++;
      $error("ERROR rdata expected %h got %h", $sampled(m_rd_exp), $sampled(rsp.rdata));
    end

  // OKAY for mapped reads, SLVERR otherwise
  a_rresp: assert property (@(posedge c0clock) disable iff (!rst_n)
      rsp.rvalid |-> rsp.rresp == (m_rd_err ? RESP_SLVERR : RESP_OKAY))
    else begin
      fail_cnt++;
      $error("ERROR rresp got %h for araddr error flag %h",
             $sampled(rsp.rresp), $sampled(m_rd_err));
    end

  // Unmapped reads answer SLVERR with zero data
  a_slverr: assert property (@(posedge c0clock) disable iff (!rst_n)
      rd_fire && !mapped(req.araddr) |=> rsp.rvalid && rsp.rresp == RESP_SLVERR && rsp.rdata == '0)
    else begin
      fail_cnt++;
      $error("ERROR unmapped read rresp %h rdata %h", $sampled(rsp.rresp), $sampled(rsp.rdata));
    end

  a_bhold: assert property (@(posedge c0clock) disable iff (!rst_n)
      rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
    else begin
      fail_cnt++;
      $error("Write response dropped or changed while bready was low");
    end

  a_rhold: assert property (@(posedge c0clock) disable iff (!rst_n)
      rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
    else begin
      fail_cnt++;
      $error("Read response dropped or changed while rready was low");
    end

endmodule

// ==== tests/clkgen_tb.sv ====
// Testbench for the clock generator bank, driving its AXI4-Lite port through the test sequence
`timescale 1ns/1ps

module clkgen_tb
  import clkgen_pkg::*;
  import axil_pkg::*;
();

  localparam int TEST_CYCLES = 10 + 330 + 550 + 250 + 160;  // Reset, div, pwm, meter, bus
  localparam int LIMIT       = TEST_CYCLES * 3 / 2;

  logic              c0clock;
  logic              rst_n;
  axil_req_t         req;
  axil_rsp_t         rsp;
  logic [NUM_CH-1:0] div_out;
  logic [NUM_CH-1:0] pwm_out;
  int                seed = 35;
  int                tests_run;
  int                tests_bad;
  int unsigned       seen_fails;  // Assertion failures charged to earlier tests
  logic [31:0]       rd_word;
  logic [GATE_W-1:0] gate;

  clkgen_top dut0 (
    .c0clock (c0clock),
    .rst_n   (rst_n),
    .req     (req),
    .rsp     (rsp),
    .div_out (div_out),
    .pwm_out (pwm_out)
  );

  bind clkgen_top clkgen_assertions u_chk (
    .c0clock (c0clock),
    .rst_n   (rst_n),
    .req     (req),
    .rsp     (rsp),
    .div_out (div_out),
    .pwm_out (pwm_out)
  );

  always #10 c0clock = ~c0clock;  // 20 ns period

  // Random ready stall of 0 to 3 cycles
  task automatic stall();
    int n;
    n = $random(seed) & 3;
    repeat (n) @(negedge c0clock);
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge c0clock);
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hf;
    while (!rsp.awready) @(negedge c0clock);
    @(negedge c0clock);  // Taken on the edge just passed
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    stall();             // bvalid has to hold meanwhile
    req.bready = 1'b1;
    while (!rsp.bvalid) @(negedge c0clock);
    @(negedge c0clock);
    req.bready = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge c0clock);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    while (!rsp.arready) @(negedge c0clock);
    @(negedge c0clock);
    req.arvalid = 1'b0;
    stall();
    data       = rsp.rdata;
    req.rready = 1'b1;
    @(negedge c0clock);
    req.rready = 1'b0;
  endtask

  task automatic set_channel(input int ch, input logic en, input pwm_mode_e mode,
                             input logic [TAP_W-1:0] tap, input logic [CNT_W-1:0] duty);
    bus_write(ADDR_CH_CFG + 8'(4 * ch), {16'h0, duty, 1'b0, tap, 1'b0, mode, en});
  endtask

  task automatic wait_done();
    logic [31:0] w;
    do bus_read(ADDR_STATUS, w); while (!w[1]);  // Polls the done bit
  endtask

  task automatic read_counts();
    for (int ch = 0; ch < NUM_CH; ch++) bus_read(ADDR_COUNT + 8'(4 * ch), rd_word);
  endtask

  task automatic finish_test(input string name);
    int unsigned now_fails;
    now_fails = dut0.u_chk.fail_cnt;
    tests_run++;
    if (now_fails != seen_fails) tests_bad++;
    $display("test %0d %s: %s, %0d assertion errors", tests_run, name,
             (now_fails == seen_fails) ? "ok" : "FAILED", now_fails - seen_fails);
    seen_fails = now_fails;
  endtask

  initial begin
    c0clock    = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    tests_run  = 0;
    tests_bad  = 0;
    seen_fails = 0;
    repeat (3) @(negedge c0clock);
    rst_n = 1'b1;
    repeat (4) @(negedge c0clock);
    finish_test("reset state");

    set_channel(0, 1'b1, PWM_OFF, 3'd0, 8'h00);  // Taps from bit 0 up to bit 7
    set_channel(1, 1'b1, PWM_2B, 3'd2, 8'h02);
    set_channel(2, 1'b1, PWM_3B, 3'd5, 8'h05);
    set_channel(3, 1'b1, PWM_8B, 3'd7, 8'h80);
    repeat (300) @(negedge c0clock);
    finish_test("divided output");

    // Every mode on every channel, first round with zero duty
    for (int k = 0; k < 8; k++) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        set_channel(ch, 1'b1, pwm_mode_e'(2'((k + ch) % 4)), 3'($random(seed)),
                    (k == 0) ? 8'h00 : 8'($random(seed)));
      end
      repeat (40) @(negedge c0clock);
    end
    finish_test("pwm compare");

    gate = 16'd100 + 16'($random(seed) & 63);  // Either side of 2**7
    set_channel(0, 1'b1, PWM_2B, 3'd0, 8'h01);
    set_channel(1, 1'b1, PWM_3B, 3'd3, 8'h04);
    set_channel(2, 1'b1, PWM_8B, 3'd7, 8'h40);
    set_channel(3, 1'b0, PWM_8B, 3'd1, 8'h10);  // Disabled, reads zero
    bus_write(ADDR_GATE, 32'(gate));
    bus_write(ADDR_START, 32'h1);
    wait_done();
    read_counts();
    finish_test("meter counts");

    bus_read(8'h40, rd_word);         // Past the count block
    bus_write(8'h14, 32'h0000_1234);  // Hole below the gate register
    bus_read(8'h2c, rd_word);
    bus_write(ADDR_GATE, 32'd60);
    bus_write(ADDR_START, 32'h1);
    repeat (5) @(negedge c0clock);
    bus_write(ADDR_START, 32'h1);     // Lands inside the window
    wait_done();
    read_counts();
    bus_write(ADDR_COUNT, 32'h0000_ffff);  // Read only
    finish_test("bus behavior");

    $display("%0d tests run, %0d passed, %0d failed, %0d assertion errors",
             tests_run, tests_run - tests_bad, tests_bad, seen_fails);
    if (tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Sum of test lengths plus half again
  initial begin
    repeat (LIMIT) @(posedge c0clock);
    $display("Watchdog expired after %0d cycles with tests still running", LIMIT);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/clkgen_pkg.sv
hdl/axil_pkg.sv
hdl/csr_axil.sv
hdl/div_pwm_channel.sv
hdl/edge_meter.sv
hdl/clkgen_top.sv
tests/clkgen_assertions.sv
tests/clkgen_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the clock generator testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module clkgen_tb -f vlog.f -o clkgen_sim
out=$(./obj_dir/clkgen_sim +verilator+error+limit+1000 || true)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
